// File: read_fabric.f
rtl/read_fabric_pkg.sv
rtl/read_arbiter.sv
rtl/read_router.sv
rtl/clint_timer.sv
rtl/read_fabric.sv
testbench/read_fabric_tb.sv

// File: rtl/clint_timer.sv
module clint_timer (
  input  logic                   clock,
  input  logic                   reset,
  // request
  input  logic                   arvalid,
  input  read_fabric_pkg::addr_t araddr,
  output logic                   arready,
  // response, always okay
  output logic                   rvalid,
  output read_fabric_pkg::data_t rdata,
  input  logic                   rready
);
  import read_fabric_pkg::*;

  mtime_t      mtime_q;
  logic        rvalid_q;
  data_t       rdata_q;
  logic [15:0] offset;
  data_t       word_sel;

  // free running
  always_ff @(posedge clock) begin
    if (reset) begin
      mtime_q <= '0;
    end else begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  // window membership is the router's job, only the offset matters here
  assign offset = araddr[15:0];

  always_comb begin
    case (offset)
      MTIME_LO_OFFSET: word_sel = mtime_q[31:0];
      MTIME_HI_OFFSET: word_sel = mtime_q[63:32];
      default:         word_sel = '0;
    endcase
  end

  assign arready = !rvalid_q;  // one entry response register

  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid_q <= 1'b0;
    end else if (arvalid && arready) begin
      rvalid_q <= 1'b1;
    end else if (rvalid_q && rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // word sampled at the address transfer
  always_ff @(posedge clock) begin
    if (arvalid && arready) rdata_q <= word_sel;
  end

  assign rvalid = rvalid_q;
  assign rdata  = rdata_q;

endmodule

// File: rtl/read_arbiter.sv
module read_arbiter (
  input  logic                   clock,
  input  logic                   reset,
  // fetch requester
  input  logic                   fetch_arvalid,
  input  read_fabric_pkg::addr_t fetch_araddr,
  output logic                   fetch_arready,
  output logic                   fetch_rvalid,
  output read_fabric_pkg::data_t fetch_rdata,
  output read_fabric_pkg::resp_t fetch_rresp,
  input  logic                   fetch_rready,
  // load requester
  input  logic                   load_arvalid,
  input  read_fabric_pkg::addr_t load_araddr,
  output logic                   load_arready,
  output logic                   load_rvalid,
  output read_fabric_pkg::data_t load_rdata,
  output read_fabric_pkg::resp_t load_rresp,
  input  logic                   load_rready,
  // shared channel toward the router
  output logic                   arvalid,
  output read_fabric_pkg::addr_t araddr,
  input  logic                   arready,
  input  logic                   rvalid,
  input  read_fabric_pkg::data_t rdata,
  input  read_fabric_pkg::resp_t rresp,
  output logic                   rready
);
  import read_fabric_pkg::*;

  arb_state_e state;
  logic       grant_load;  // 1 = load owns the channel
  logic       last_load;   // winner of the previous arbitration
  addr_t      addr_q;      // held address for a stable payload
  logic       pick_load;

  // round robin, only matters on a tie
  assign pick_load = load_arvalid && (!fetch_arvalid || !last_load);

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= ARB_IDLE;
      grant_load <= 1'b0;
      last_load  <= 1'b1;  // so fetch takes the first tie
    end else begin
      case (state)
        ARB_IDLE: begin
          if (fetch_arvalid || load_arvalid) begin
            grant_load <= pick_load;
            last_load  <= pick_load;
            state      <= ARB_ADDR;
          end
        end
        ARB_ADDR: begin
          if (arready) state <= ARB_RESP;  // arvalid is high here
        end
        ARB_RESP: begin
          if (rvalid && rready) state <= ARB_IDLE;
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  // payload register
  always_ff @(posedge clock) begin
    if (state == ARB_IDLE && (fetch_arvalid || load_arvalid)) begin
      addr_q <= pick_load ? load_araddr : fetch_araddr;
    end
  end

  assign arvalid = (state == ARB_ADDR);
  assign araddr  = addr_q;

  // address handshake goes back to the granted side only
  assign fetch_arready = (state == ARB_ADDR) && !grant_load && arready;
  assign load_arready  = (state == ARB_ADDR) && grant_load && arready;

  // response steering
  assign fetch_rvalid = (state == ARB_RESP) && !grant_load && rvalid;
  assign load_rvalid  = (state == ARB_RESP) && grant_load && rvalid;
  assign fetch_rdata  = rdata;
  assign load_rdata   = rdata;
  assign fetch_rresp  = rresp;
  assign load_rresp   = rresp;

  assign rready = (state == ARB_RESP) && (grant_load ? load_rready : fetch_rready);

endmodule

// File: rtl/read_fabric.sv
module read_fabric #(
  parameter read_fabric_pkg::addr_t CLINT_BASE = 32'h0200_0000,
  parameter read_fabric_pkg::addr_t CLINT_SIZE = 32'h0001_0000
) (
  input  logic                   clock,
  input  logic                   reset,
  // fetch requester
  input  logic                   fetch_arvalid,
  input  read_fabric_pkg::addr_t fetch_araddr,
  output logic                   fetch_arready,
  output logic                   fetch_rvalid,
  output read_fabric_pkg::data_t fetch_rdata,
  output read_fabric_pkg::resp_t fetch_rresp,
  input  logic                   fetch_rready,
  // load requester
  input  logic                   load_arvalid,
  input  read_fabric_pkg::addr_t load_araddr,
  output logic                   load_arready,
  output logic                   load_rvalid,
  output read_fabric_pkg::data_t load_rdata,
  output read_fabric_pkg::resp_t load_rresp,
  input  logic                   load_rready,
  // external master port
  output logic                   m_arvalid,
  output read_fabric_pkg::addr_t m_araddr,
  input  logic                   m_arready,
  input  logic                   m_rvalid,
  input  read_fabric_pkg::data_t m_rdata,
  input  read_fabric_pkg::resp_t m_rresp,
  output logic                   m_rready
);
  import read_fabric_pkg::*;

  // arbiter to router
  logic  arb_arvalid;
  addr_t arb_araddr;
  logic  arb_arready;
  logic  arb_rvalid;
  data_t arb_rdata;
  resp_t arb_rresp;
  logic  arb_rready;

  // router to timer
  logic  t_arvalid;
  addr_t t_araddr;
  logic  t_arready;
  logic  t_rvalid;
  data_t t_rdata;
  logic  t_rready;

  read_arbiter i_read_arbiter (
    .clock         (clock),
    .reset         (reset),
    .fetch_arvalid (fetch_arvalid),
    .fetch_araddr  (fetch_araddr),
    .fetch_arready (fetch_arready),
    .fetch_rvalid  (fetch_rvalid),
    .fetch_rdata   (fetch_rdata),
    .fetch_rresp   (fetch_rresp),
    .fetch_rready  (fetch_rready),
    .load_arvalid  (load_arvalid),
    .load_araddr   (load_araddr),
    .load_arready  (load_arready),
    .load_rvalid   (load_rvalid),
    .load_rdata    (load_rdata),
    .load_rresp    (load_rresp),
    .load_rready   (load_rready),
    .arvalid       (arb_arvalid),
    .araddr        (arb_araddr),
    .arready       (arb_arready),
    .rvalid        (arb_rvalid),
    .rdata         (arb_rdata),
    .rresp         (arb_rresp),
    .rready        (arb_rready)
  );

  read_router #(
    .CLINT_BASE (CLINT_BASE),
    .CLINT_SIZE (CLINT_SIZE)
  ) i_read_router (
    .clock     (clock),
    .reset     (reset),
    .arvalid   (arb_arvalid),
    .araddr    (arb_araddr),
    .arready   (arb_arready),
    .rvalid    (arb_rvalid),
    .rdata     (arb_rdata),
    .rresp     (arb_rresp),
    .rready    (arb_rready),
    .m_arvalid (m_arvalid),
    .m_araddr  (m_araddr),
    .m_arready (m_arready),
    .m_rvalid  (m_rvalid),
    .m_rdata   (m_rdata),
    .m_rresp   (m_rresp),
    .m_rready  (m_rready),
    .t_arvalid (t_arvalid),
    .t_araddr  (t_araddr),
    .t_arready (t_arready),
    .t_rvalid  (t_rvalid),
    .t_rdata   (t_rdata),
    .t_rready  (t_rready)
  );

  clint_timer i_clint_timer (
    .clock   (clock),
    .reset   (reset),
    .arvalid (t_arvalid),
    .araddr  (t_araddr),
    .arready (t_arready),
    .rvalid  (t_rvalid),
    .rdata   (t_rdata),
    .rready  (t_rready)
  );

endmodule

// File: rtl/read_fabric_pkg.sv
package read_fabric_pkg;

  // widths with a meaning
  typedef logic [31:0] addr_t;   // byte address of a read
  typedef logic [31:0] data_t;   // one read data word
  typedef logic [1:0]  resp_t;   // read response code
  typedef logic [63:0] mtime_t;  // timer count

  // response codes, only okay is produced inside the fabric
  localparam resp_t RESP_OKAY = 2'b00;

  // mtime words inside the clint window
  localparam logic [15:0] MTIME_LO_OFFSET = 16'hBFF8;
  localparam logic [15:0] MTIME_HI_OFFSET = 16'hBFFC;

  // arbiter FSM
  typedef enum logic [1:0] {
    ARB_IDLE,  // waiting for any requester
    ARB_ADDR,  // address offered downstream
    ARB_RESP   // waiting for the single response beat
  } arb_state_e;

endpackage

// File: rtl/read_router.sv
module read_router #(
  parameter read_fabric_pkg::addr_t CLINT_BASE = 32'h0200_0000,
  parameter read_fabric_pkg::addr_t CLINT_SIZE = 32'h0001_0000
) (
  input  logic                   clock,
  input  logic                   reset,
  // from the arbiter
  input  logic                   arvalid,
  input  read_fabric_pkg::addr_t araddr,
  output logic                   arready,
  output logic                   rvalid,
  output read_fabric_pkg::data_t rdata,
  output read_fabric_pkg::resp_t rresp,
  input  logic                   rready,
  // external master port
  output logic                   m_arvalid,
  output read_fabric_pkg::addr_t m_araddr,
  input  logic                   m_arready,
  input  logic                   m_rvalid,
  input  read_fabric_pkg::data_t m_rdata,
  input  read_fabric_pkg::resp_t m_rresp,
  output logic                   m_rready,
  // clint timer
  output logic                   t_arvalid,
  output read_fabric_pkg::addr_t t_araddr,
  input  logic                   t_arready,
  input  logic                   t_rvalid,
  input  read_fabric_pkg::data_t t_rdata,
  output logic                   t_rready
);
  import read_fabric_pkg::*;

  logic  in_window;
  logic  route_timer_q;  // route of the read in flight
  addr_t window_offset;

  // below the base wraps to a large value, so one compare covers both ends
  assign window_offset = araddr - CLINT_BASE;
  assign in_window     = window_offset < CLINT_SIZE;

  // request path, combinational
  assign m_arvalid = arvalid && !in_window;
  assign t_arvalid = arvalid && in_window;
  assign m_araddr  = araddr;
  assign t_araddr  = araddr;
  assign arready   = in_window ? t_arready : m_arready;

  always_ff @(posedge clock) begin
    if (reset) begin
      route_timer_q <= 1'b0;
    end else if (arvalid && arready) begin
      route_timer_q <= in_window;  // held until the next address transfer
    end
  end

  // response path follows the latched route, not the live address
  assign rvalid   = route_timer_q ? t_rvalid : m_rvalid;
  assign rdata    = route_timer_q ? t_rdata : m_rdata;
  assign rresp    = route_timer_q ? RESP_OKAY : m_rresp;
  assign m_rready = rready && !route_timer_q;
  assign t_rready = rready && route_timer_q;

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module read_fabric_tb \
  -f read_fabric.f --Mdir obj_dir -o read_fabric_sim

./obj_dir/read_fabric_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Testbench passed$" sim.log; then
  exit 0
fi
exit 1

// File: testbench/read_fabric_tb.sv
module read_fabric_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import read_fabric_pkg::*;

  localparam addr_t CLINT_BASE  = 32'h0200_0000;
  localparam addr_t CLINT_SIZE  = 32'h0001_0000;
  localparam data_t EXT_PATTERN = 32'hA5A5_5A5A;  // external data = address ^ pattern
  localparam int    NUM_READS   = 200;
  localparam int    TIMEOUT     = 1000;

  logic       clock = 1'b0;
  logic       reset;
  // index 0 is fetch, 1 is load
  logic [1:0] req_arvalid;
  logic [1:0] req_arready;
  logic [1:0] req_rvalid;
  logic [1:0] req_rready;
  addr_t      req_araddr [2];
  data_t      req_rdata [2];
  resp_t      req_rresp [2];
  logic       m_arvalid;
  addr_t      m_araddr;
  logic       m_arready;
  logic       m_rvalid;
  data_t      m_rdata;
  resp_t      m_rresp;
  logic       m_rready;

  integer     seed;
  mtime_t     cycle_count;    // edges since reset release
  logic [1:0] waiting_resp;   // side has an address accepted
  logic       requests_done;
  int         ext_expected;
  int         ext_seen;
  logic       expect_side;
  logic       other_pending;  // loser of the last transfer was still valid

  read_fabric i_read_fabric (
    .clock (clock), .reset (reset),
    .fetch_arvalid (req_arvalid[0]), .fetch_araddr (req_araddr[0]),
    .fetch_arready (req_arready[0]), .fetch_rvalid (req_rvalid[0]),
    .fetch_rdata (req_rdata[0]), .fetch_rresp (req_rresp[0]), .fetch_rready (req_rready[0]),
    .load_arvalid (req_arvalid[1]), .load_araddr (req_araddr[1]),
    .load_arready (req_arready[1]), .load_rvalid (req_rvalid[1]),
    .load_rdata (req_rdata[1]), .load_rresp (req_rresp[1]), .load_rready (req_rready[1]),
    .m_arvalid (m_arvalid), .m_araddr (m_araddr), .m_arready (m_arready),
    .m_rvalid (m_rvalid), .m_rdata (m_rdata), .m_rresp (m_rresp), .m_rready (m_rready)
  );

  always #5 clock = ~clock;

  always @(posedge clock) begin
    if (reset) cycle_count <= '0;
    else cycle_count <= cycle_count + 64'd1;
  end

  task automatic fail_run();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    fail_run();
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: no %s within %0d cycles", what, TIMEOUT);
    fail_run();
  endtask

  function automatic logic in_clint(input addr_t addr);
    return (addr >= CLINT_BASE) && (addr < CLINT_BASE + CLINT_SIZE);
  endfunction

  // per side checks in mid cycle
  task automatic watch_side(input logic side);
    if (req_arready[side]) begin
      assert (req_arvalid[side]) else report_error("arready without a request");
    end
    if (req_rvalid[side]) begin
      assert (waiting_resp[side]) else report_error("rvalid on the side with no read");
    end
    if (req_rvalid[side] && !req_rready[side]) begin
      assert (!m_arvalid) else report_error("new external request during a stalled response");
    end
    if (req_arvalid[side] && req_arready[side]) begin
      if (other_pending) begin
        assert (side == expect_side) else report_error("same side won twice while other waited");
      end
      expect_side   = ~side;
      other_pending = req_arvalid[~side];
    end
  endtask

  always @(negedge clock) begin
    if (!reset) begin
      watch_side(1'b0);
      watch_side(1'b1);
      assert (!(m_arvalid && in_clint(m_araddr))) else report_error("timer read on m_arvalid");
    end
  end

  task automatic check_response(input addr_t addr, input data_t data, input resp_t resp,
                                input mtime_t addr_cycle, input mtime_t resp_cycle);
    if (!in_clint(addr)) begin
      assert (data == (addr ^ EXT_PATTERN) && resp == RESP_OKAY)
        else report_error($sformatf("ext read %h got %h resp %0d", addr, data, resp));
    end else if (addr[15:0] == MTIME_LO_OFFSET) begin
      assert (resp == RESP_OKAY && {32'd0, data} + 64'd1 >= addr_cycle &&
              {32'd0, data} <= resp_cycle)
        else report_error($sformatf("mtime low %0d outside %0d..%0d", data, addr_cycle,
                                    resp_cycle));
    end else begin
      // mtime high stays zero in a run this short
      assert (data == '0 && resp == RESP_OKAY)
        else report_error($sformatf("timer read %h got %h resp %0d", addr, data, resp));
    end
  endtask

  task automatic run_requester(input logic side);
    addr_t       addr;
    logic [31:0] r;
    data_t       got_data;
    resp_t       got_resp;
    mtime_t      addr_cycle;
    mtime_t      resp_cycle;
    int          stall;
    int          waited;
    logic        seen;
    logic        done;
    for (int n = 0; n < NUM_READS; n++) begin
      r = $random(seed);
      repeat (r[1:0]) begin
        @(posedge clock);
        #1;
      end
      r = $random(seed);
      case (r[2:0])
        3'd0: addr = CLINT_BASE + {16'd0, MTIME_LO_OFFSET};
        3'd1: addr = CLINT_BASE + {16'd0, MTIME_HI_OFFSET};
        3'd2: addr = CLINT_BASE + {16'd0, r[17:4], 2'b00};  // any window word
        default: begin
          addr = $random(seed);
          if (in_clint(addr)) addr = addr ^ 32'h8000_0000;
        end
      endcase
      if (!in_clint(addr)) ext_expected = ext_expected + 1;
      req_arvalid[side] = 1'b1;
      req_araddr[side]  = addr;
      done   = 1'b0;
      waited = 0;
      while (!done) begin
        @(negedge clock);
        if (req_arvalid[side] && req_arready[side]) begin
          done       = 1'b1;
          addr_cycle = cycle_count;
        end else begin
          waited++;
          if (waited > TIMEOUT) report_timeout("address handshake on a requester");
        end
      end
      @(posedge clock);
      #1;
      req_arvalid[side]  = 1'b0;
      req_araddr[side]   = $random(seed);  // live address moves on
      waiting_resp[side] = 1'b1;
      r     = $random(seed);
      stall = int'(r[1:0]);
      req_rready[side] = (stall == 0);
      seen   = 1'b0;
      done   = 1'b0;
      waited = 0;
      while (!done) begin
        @(negedge clock);
        if (req_rvalid[side]) begin
          if (seen) begin
            assert (req_rdata[side] == got_data && req_rresp[side] == got_resp)
              else report_error("response changed while stalled");
          end
          got_data = req_rdata[side];
          got_resp = req_rresp[side];
          seen     = 1'b1;
          if (req_rready[side]) begin
            done       = 1'b1;
            resp_cycle = cycle_count;
          end
        end
        if (!done) begin
          waited++;
          if (waited > TIMEOUT) report_timeout("response on a requester");
          @(posedge clock);
          #1;
          if (seen && stall > 0) stall--;
          req_rready[side] = (stall == 0);
        end
      end
      @(posedge clock);
      #1;
      req_rready[side]   = 1'b0;
      waiting_resp[side] = 1'b0;
      check_response(addr, got_data, got_resp, addr_cycle, resp_cycle);
    end
  endtask

  // external memory slave
  task automatic respond_external();
    addr_t       addr;
    logic [31:0] r;
    int          waited;
    int          lat;
    logic        done;
    while (!requests_done) begin
      done   = 1'b0;
      waited = 0;
      while (!done && !requests_done) begin
        @(negedge clock);
        if (m_arvalid) begin
          done = 1'b1;
        end else begin
          waited++;
          if (waited > TIMEOUT) report_timeout("external read request");
        end
      end
      if (done) begin
        addr = m_araddr;
        r    = $random(seed);
        @(posedge clock);
        #1;
        for (int k = 0; k <= int'(r[1:0]); k++) begin
          if (k == int'(r[1:0])) m_arready = 1'b1;
          @(negedge clock);
          assert (m_arvalid && m_araddr == addr) else report_error("m_araddr not held");
          @(posedge clock);
          #1;
        end
        m_arready = 1'b0;
        ext_seen  = ext_seen + 1;
        lat = 1 + int'(r[9:2] % 8'd3);
        repeat (lat - 1) begin
          @(posedge clock);
          #1;
        end
        m_rvalid = 1'b1;
        m_rdata  = addr ^ EXT_PATTERN;
        m_rresp  = RESP_OKAY;
        done     = 1'b0;
        waited   = 0;
        while (!done) begin
          @(negedge clock);
          if (m_rready) begin
            done = 1'b1;
          end else begin
            waited++;
            if (waited > TIMEOUT) report_timeout("m_rready from the fabric");
          end
        end
        @(posedge clock);
        #1;
        m_rvalid = 1'b0;
        m_rdata  = $random(seed);
      end
    end
  endtask

  initial begin
    seed          = 32'h9350;
    reset         = 1'b1;
    req_arvalid   = '0;
    req_rready    = '0;
    req_araddr[0] = '0;
    req_araddr[1] = '0;
    m_arready     = 1'b0;
    m_rvalid      = 1'b0;
    m_rdata       = '0;
    m_rresp       = RESP_OKAY;
    waiting_resp  = '0;
    requests_done = 1'b0;
    ext_expected  = 0;
    ext_seen      = 0;
    expect_side   = 1'b0;
    other_pending = 1'b0;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    repeat (3) begin
      @(negedge clock);
      assert (req_arready == '0 && req_rvalid == '0 && !m_arvalid)
        else report_error("handshake output high before any request");
    end
    @(posedge clock);
    #1;
    fork
      begin
        fork
          run_requester(1'b0);
          run_requester(1'b1);
        join
        requests_done = 1'b1;
      end
      respond_external();
    join
    if (ext_seen != ext_expected) begin
      report_error($sformatf("%0d external reads seen, %0d issued", ext_seen, ext_expected));
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule
